// File: branch_unit.sv
////////////////////////////////////////////////////////////
// branch unit, resolves jumps and branches in decode
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module branch_unit import mips_pkg::*; (
	input  dec_t    dec_i,
	input  word_t   pc_i,
	input  word_t   reg1_i,
	input  word_t   reg2_i,
	input  logic    stall_i,
	output branch_t branch_o,
	output word_t   link_addr_o
);

	word_t pc_plus_4;
	word_t pc_plus_8;
	word_t br_offset;
	word_t target;
	logic  cond;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8;
	assign br_offset = {{14{dec_i.instr_idx[15]}}, dec_i.instr_idx[15:0], 2'b00};

	always_comb begin
		cond   = 1'b0;
		target = '0;
		case (dec_i.br_kind)
			BR_JUMP: begin
				cond   = 1'b1;
				target = {pc_plus_4[31:28], dec_i.instr_idx, 2'b00};
			end
			BR_JUMP_REG: begin
				cond   = 1'b1;
				target = reg1_i;
			end
			BR_EQ:  cond = (reg1_i == reg2_i);
			BR_NE:  cond = (reg1_i != reg2_i);
			BR_GTZ: cond = ($signed(reg1_i) > 32'sd0);
			BR_LEZ: cond = ($signed(reg1_i) <= 32'sd0);
			default: ;
		endcase
		if (dec_i.br_kind inside {BR_EQ, BR_NE, BR_GTZ, BR_LEZ}) begin
			target = pc_plus_4 + br_offset;	// pc-relative
		end
	end

	assign branch_o.flag   = cond & ~stall_i;	// no redirect while held
	assign branch_o.target = target;
	assign link_addr_o     = dec_i.link ? pc_plus_8 : '0;

endmodule

// File: id_ex_reg.sv
////////////////////////////////////////////////////////////
// decode-to-execute register, bubbles and delay-slot flag
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module id_ex_reg import mips_pkg::*; (
	input  logic    clk,
	input  logic    rst_i,
	input  logic    id_valid_i,
	input  logic    stall_i,
	input  dec_t    dec_i,
	input  word_t   reg1_i,
	input  word_t   reg2_i,
	input  word_t   link_addr_i,
	input  logic    taken_i,
	output ex_req_t ex_req_o
);

	logic accept;
	logic ds_q;		// next accepted instruction is a delay slot

	assign accept = id_valid_i & ~stall_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ds_q                  <= 1'b0;
			ex_req_o.valid        <= 1'b0;
			ex_req_o.aluop        <= ALU_NOP;
			ex_req_o.alusel       <= SEL_NOP;
			ex_req_o.wreg         <= 1'b0;
			ex_req_o.in_delayslot <= 1'b0;
		end else if (accept) begin
			ds_q                  <= taken_i;
			ex_req_o.valid        <= 1'b1;
			ex_req_o.aluop        <= dec_i.aluop;
			ex_req_o.alusel       <= dec_i.alusel;
			ex_req_o.wreg         <= dec_i.wreg;
			ex_req_o.in_delayslot <= ds_q;
			ex_req_o.reg1         <= reg1_i;
			ex_req_o.reg2         <= reg2_i;
			ex_req_o.wd           <= dec_i.wd;
			ex_req_o.link_addr    <= link_addr_i;
		end else begin
			ex_req_o.valid        <= 1'b0;	// bubble
			ex_req_o.aluop        <= ALU_NOP;
			ex_req_o.alusel       <= SEL_NOP;
			ex_req_o.wreg         <= 1'b0;
			ex_req_o.in_delayslot <= 1'b0;
		end
	end

endmodule

// File: id_stage.f
mips_pkg.sv
regfile.sv
inst_decoder.sv
operand_fwd.sv
branch_unit.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

// File: id_stage.sv
////////////////////////////////////////////////////////////
// MIPS decode stage top level
// decoder, operand forwarding, branch unit and ID/EX register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module id_stage import mips_pkg::*; (
	input  logic    clk,
	input  logic    rst_i,
	input  word_t   pc_i,
	input  word_t   inst_i,
	input  logic    id_valid_i,
	input  fwd_t    ex_fwd_i,
	input  fwd_t    mem_fwd_i,
	input  logic    ex_is_load_i,
	input  fwd_t    wb_i,
	output ex_req_t ex_req_o,
	output branch_t branch_o,
	output logic    stall_o
);

	dec_t      dec;
	reg_addr_t raddr1;
	reg_addr_t raddr2;
	word_t     rdata1;
	word_t     rdata2;
	word_t     reg1;
	word_t     reg2;
	word_t     link_addr;

	regfile u_regfile (.clk(clk), .rst_i(rst_i), .wb_i(wb_i),
		.raddr1_i(raddr1), .raddr2_i(raddr2), .rdata1_o(rdata1), .rdata2_o(rdata2));

	inst_decoder u_decoder (.inst_i(inst_i), .dec_o(dec));

	operand_fwd u_operand_fwd (.dec_i(dec), .ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i),
		.ex_is_load_i(ex_is_load_i), .rdata1_i(rdata1), .rdata2_i(rdata2),
		.raddr1_o(raddr1), .raddr2_o(raddr2), .reg1_o(reg1), .reg2_o(reg2),
		.stall_o(stall_o));

	branch_unit u_branch (.dec_i(dec), .pc_i(pc_i), .reg1_i(reg1), .reg2_i(reg2),
		.stall_i(stall_o), .branch_o(branch_o), .link_addr_o(link_addr));

	// taken flag marks the next accepted instruction
	id_ex_reg u_id_ex (.clk(clk), .rst_i(rst_i), .id_valid_i(id_valid_i),
		.stall_i(stall_o), .dec_i(dec), .reg1_i(reg1), .reg2_i(reg2),
		.link_addr_i(link_addr), .taken_i(branch_o.flag), .ex_req_o(ex_req_o));

endmodule

// File: inst_decoder.sv
////////////////////////////////////////////////////////////
// instruction decoder
// opcode and function table into the decoded-control struct
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module inst_decoder import mips_pkg::*; (
	input  word_t inst_i,
	output dec_t  dec_o
);

	opcode_t     op;
	opcode_t     func;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   rd;
	logic [4:0]  sa;
	logic [15:0] imm16;
	logic        rr;		// register-register form

	assign op    = inst_i[31:26];
	assign rs    = inst_i[25:21];
	assign rt    = inst_i[20:16];
	assign rd    = inst_i[15:11];
	assign sa    = inst_i[10:6];
	assign func  = inst_i[5:0];
	assign imm16 = inst_i[15:0];

	always_comb begin
		dec_o           = '0;
		dec_o.aluop     = ALU_NOP;
		dec_o.alusel    = SEL_NOP;
		dec_o.br_kind   = BR_NONE;
		dec_o.wd        = rd;
		dec_o.reg1_addr = rs;
		dec_o.reg2_addr = rt;
		dec_o.instr_idx = inst_i[25:0];
		rr              = 1'b0;

		case (op)
			OP_SPECIAL: begin
				if ((rs == '0) && (func inside {FN_SLL, FN_SRL, FN_SRA})) begin
					dec_o.alusel    = SEL_SHIFT;
					dec_o.wreg      = 1'b1;
					dec_o.reg2_read = 1'b1;
					dec_o.imm       = {27'd0, sa};	// shift amount as operand 1
					case (func)
						FN_SLL:  dec_o.aluop = ALU_SLL;
						FN_SRL:  dec_o.aluop = ALU_SRL;
						default: dec_o.aluop = ALU_SRA;
					endcase
				end else if (sa == '0) begin
					rr = 1'b1;
					case (func)
						FN_OR:   begin dec_o.aluop = ALU_OR;   dec_o.alusel = SEL_LOGIC; end
						FN_AND:  begin dec_o.aluop = ALU_AND;  dec_o.alusel = SEL_LOGIC; end
						FN_XOR:  begin dec_o.aluop = ALU_XOR;  dec_o.alusel = SEL_LOGIC; end
						FN_NOR:  begin dec_o.aluop = ALU_NOR;  dec_o.alusel = SEL_LOGIC; end
						FN_SLLV: begin dec_o.aluop = ALU_SLL;  dec_o.alusel = SEL_SHIFT; end
						FN_SRLV: begin dec_o.aluop = ALU_SRL;  dec_o.alusel = SEL_SHIFT; end
						FN_SRAV: begin dec_o.aluop = ALU_SRA;  dec_o.alusel = SEL_SHIFT; end
						FN_SLT:  begin dec_o.aluop = ALU_SLT;  dec_o.alusel = SEL_ARITHMETIC; end
						FN_SLTU: begin dec_o.aluop = ALU_SLTU; dec_o.alusel = SEL_ARITHMETIC; end
						FN_ADD:  begin dec_o.aluop = ALU_ADD;  dec_o.alusel = SEL_ARITHMETIC; end
						FN_ADDU: begin dec_o.aluop = ALU_ADDU; dec_o.alusel = SEL_ARITHMETIC; end
						FN_SUB:  begin dec_o.aluop = ALU_SUB;  dec_o.alusel = SEL_ARITHMETIC; end
						FN_SUBU: begin dec_o.aluop = ALU_SUBU; dec_o.alusel = SEL_ARITHMETIC; end
						FN_JR: begin
							rr              = 1'b0;
							dec_o.aluop     = ALU_JR;
							dec_o.alusel    = SEL_JUMP_BRANCH;
							dec_o.br_kind   = BR_JUMP_REG;
							dec_o.reg1_read = 1'b1;
						end
						FN_JALR: begin
							rr              = 1'b0;
							dec_o.aluop     = ALU_JALR;
							dec_o.alusel    = SEL_JUMP_BRANCH;
							dec_o.br_kind   = BR_JUMP_REG;
							dec_o.reg1_read = 1'b1;
							dec_o.wreg      = 1'b1;	// link into rd
							dec_o.link      = 1'b1;
						end
						default: rr = 1'b0;
					endcase
					if (rr) begin
						dec_o.wreg      = 1'b1;
						dec_o.reg1_read = 1'b1;
						dec_o.reg2_read = 1'b1;
					end
				end
			end

			OP_ORI, OP_ANDI, OP_XORI, OP_LUI: begin
				dec_o.alusel    = SEL_LOGIC;
				dec_o.wreg      = 1'b1;
				dec_o.wd        = rt;
				dec_o.reg1_read = 1'b1;
				dec_o.imm       = (op == OP_LUI) ? {imm16, 16'h0} : {16'h0, imm16};
				case (op)
					OP_ANDI: dec_o.aluop = ALU_AND;
					OP_XORI: dec_o.aluop = ALU_XOR;
					default: dec_o.aluop = ALU_OR;	// ori, lui
				endcase
			end

			OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU: begin
				dec_o.alusel    = SEL_ARITHMETIC;
				dec_o.wreg      = 1'b1;
				dec_o.wd        = rt;
				dec_o.reg1_read = 1'b1;
				dec_o.imm       = {{16{imm16[15]}}, imm16};
				case (op)
					OP_SLTI:  dec_o.aluop = ALU_SLT;
					OP_SLTIU: dec_o.aluop = ALU_SLTU;
					OP_ADDI:  dec_o.aluop = ALU_ADDI;
					default:  dec_o.aluop = ALU_ADDIU;
				endcase
			end

			OP_J, OP_JAL: begin
				dec_o.alusel  = SEL_JUMP_BRANCH;
				dec_o.br_kind = BR_JUMP;
				dec_o.aluop   = (op == OP_JAL) ? ALU_JAL : ALU_J;
				dec_o.wreg    = (op == OP_JAL);
				dec_o.link    = (op == OP_JAL);
				dec_o.wd      = LINK_REG;
			end

			OP_BEQ, OP_BNE: begin
				dec_o.alusel    = SEL_JUMP_BRANCH;
				dec_o.aluop     = (op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				dec_o.br_kind   = (op == OP_BEQ) ? BR_EQ : BR_NE;
				dec_o.reg1_read = 1'b1;
				dec_o.reg2_read = 1'b1;
			end

			OP_BGTZ, OP_BLEZ: begin
				dec_o.alusel    = SEL_JUMP_BRANCH;
				dec_o.aluop     = (op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
				dec_o.br_kind   = (op == OP_BGTZ) ? BR_GTZ : BR_LEZ;
				dec_o.reg1_read = 1'b1;
			end

			OP_LW: begin
				dec_o.aluop     = ALU_LW;
				dec_o.alusel    = SEL_LOAD_STORE;
				dec_o.wreg      = 1'b1;
				dec_o.wd        = rt;
				dec_o.reg1_read = 1'b1;
			end

			OP_SW: begin
				dec_o.aluop     = ALU_SW;
				dec_o.alusel    = SEL_LOAD_STORE;
				dec_o.reg1_read = 1'b1;
				dec_o.reg2_read = 1'b1;	// store data
			end

			default: ;	// undecoded, stays a NOP
		endcase
	end

endmodule

// File: mips_pkg.sv
////////////////////////////////////////////////////////////
// MIPS decode stage package
// widths, instruction encodings, ALU codes and stage structs
////////////////////////////////////////////////////////////
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;	// op and func fields
	typedef logic [25:0] index_t;	// jump index, low half is the branch offset

	localparam int        REG_NUM  = 32;
	localparam reg_addr_t LINK_REG = 5'd31;

	////////////////////////////////////////////////////////////
	// opcodes
	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_ORI     = 6'b001101;
	localparam opcode_t OP_ANDI    = 6'b001100;
	localparam opcode_t OP_XORI    = 6'b001110;
	localparam opcode_t OP_LUI     = 6'b001111;
	localparam opcode_t OP_SLTI    = 6'b001010;
	localparam opcode_t OP_SLTIU   = 6'b001011;
	localparam opcode_t OP_ADDI    = 6'b001000;
	localparam opcode_t OP_ADDIU   = 6'b001001;
	localparam opcode_t OP_J       = 6'b000010;
	localparam opcode_t OP_JAL     = 6'b000011;
	localparam opcode_t OP_BEQ     = 6'b000100;
	localparam opcode_t OP_BNE     = 6'b000101;
	localparam opcode_t OP_BGTZ    = 6'b000111;
	localparam opcode_t OP_BLEZ    = 6'b000110;
	localparam opcode_t OP_LW      = 6'b100011;
	localparam opcode_t OP_SW      = 6'b101011;

	////////////////////////////////////////////////////////////
	// SPECIAL function codes
	localparam opcode_t FN_OR   = 6'b100101;
	localparam opcode_t FN_AND  = 6'b100100;
	localparam opcode_t FN_XOR  = 6'b100110;
	localparam opcode_t FN_NOR  = 6'b100111;
	localparam opcode_t FN_SLLV = 6'b000100;
	localparam opcode_t FN_SRLV = 6'b000110;
	localparam opcode_t FN_SRAV = 6'b000111;
	localparam opcode_t FN_SLL  = 6'b000000;
	localparam opcode_t FN_SRL  = 6'b000010;
	localparam opcode_t FN_SRA  = 6'b000011;
	localparam opcode_t FN_SLT  = 6'b101010;
	localparam opcode_t FN_SLTU = 6'b101011;
	localparam opcode_t FN_ADD  = 6'b100000;
	localparam opcode_t FN_ADDU = 6'b100001;
	localparam opcode_t FN_SUB  = 6'b100010;
	localparam opcode_t FN_SUBU = 6'b100011;
	localparam opcode_t FN_JR   = 6'b001000;
	localparam opcode_t FN_JALR = 6'b001001;

	typedef enum logic [7:0] {
		ALU_NOP  = 8'b00000000, ALU_OR    = 8'b00100101, ALU_AND  = 8'b00100100,
		ALU_XOR  = 8'b00100110, ALU_NOR   = 8'b00100111, ALU_SLL  = 8'b01111100,
		ALU_SRL  = 8'b00000010, ALU_SRA   = 8'b00000011, ALU_SLT  = 8'b00101010,
		ALU_SLTU = 8'b00101011, ALU_ADD   = 8'b00100000, ALU_ADDU = 8'b00100001,
		ALU_ADDI = 8'b01010101, ALU_ADDIU = 8'b01010110, ALU_SUB  = 8'b00100010,
		ALU_SUBU = 8'b00100011, ALU_J     = 8'b01001111, ALU_JAL  = 8'b01010000,
		ALU_JR   = 8'b00001000, ALU_JALR  = 8'b00001001, ALU_BEQ  = 8'b01010001,
		ALU_BNE  = 8'b01010010, ALU_BGTZ  = 8'b01010100, ALU_BLEZ = 8'b01010011,
		ALU_LW   = 8'b11100011, ALU_SW    = 8'b11101011
	} aluop_e;

	typedef enum logic [2:0] {
		SEL_NOP = 3'b000, SEL_LOGIC = 3'b001, SEL_SHIFT = 3'b010,
		SEL_ARITHMETIC = 3'b100, SEL_JUMP_BRANCH = 3'b110, SEL_LOAD_STORE = 3'b111
	} alusel_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_JUMP, BR_JUMP_REG, BR_EQ, BR_NE, BR_GTZ, BR_LEZ
	} br_kind_e;

	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		word_t     wdata;
	} fwd_t;

	typedef struct packed {
		aluop_e    aluop;
		alusel_e   alusel;
		br_kind_e  br_kind;
		logic      wreg;
		reg_addr_t wd;
		logic      reg1_read;
		logic      reg2_read;
		reg_addr_t reg1_addr;
		reg_addr_t reg2_addr;
		word_t     imm;
		logic      link;		// link address is written
		index_t    instr_idx;
	} dec_t;

	typedef struct packed {
		logic      valid;
		aluop_e    aluop;
		alusel_e   alusel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t wd;
		logic      wreg;
		word_t     link_addr;
		logic      in_delayslot;
	} ex_req_t;

	typedef struct packed {
		logic  flag;
		word_t target;
	} branch_t;

endpackage

// File: operand_fwd.sv
////////////////////////////////////////////////////////////
// operand selection with EX/MEM forwarding
// immediate substitution and load-use stall detection
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module operand_fwd import mips_pkg::*; (
	input  dec_t      dec_i,
	input  fwd_t      ex_fwd_i,
	input  fwd_t      mem_fwd_i,
	input  logic      ex_is_load_i,
	input  word_t     rdata1_i,
	input  word_t     rdata2_i,
	output reg_addr_t raddr1_o,
	output reg_addr_t raddr2_o,
	output word_t     reg1_o,
	output word_t     reg2_o,
	output logic      stall_o
);

	logic stall1;
	logic stall2;

	// one operand, priority load-use > EX > MEM > regfile > imm
	function automatic word_t sel_operand(input logic rd_en, input reg_addr_t addr,
		input word_t rdata, output logic hazard);
		word_t res;
		hazard = 1'b0;
		if (rd_en && ex_is_load_i && (ex_fwd_i.wd == addr)) begin
			hazard = 1'b1;
			res    = '0;
		end else if (rd_en && ex_fwd_i.wreg && (ex_fwd_i.wd == addr)) begin
			res = ex_fwd_i.wdata;
		end else if (rd_en && mem_fwd_i.wreg && (mem_fwd_i.wd == addr)) begin
			res = mem_fwd_i.wdata;
		end else if (rd_en) begin
			res = rdata;
		end else begin
			res = dec_i.imm;
		end
		return res;
	endfunction

	assign raddr1_o = dec_i.reg1_addr;
	assign raddr2_o = dec_i.reg2_addr;

	always_comb begin
		reg1_o = sel_operand(dec_i.reg1_read, dec_i.reg1_addr, rdata1_i, stall1);
		reg2_o = sel_operand(dec_i.reg2_read, dec_i.reg2_addr, rdata2_i, stall2);
	end

	assign stall_o = stall1 | stall2;

endmodule

// File: regfile.sv
////////////////////////////////////////////////////////////
// register file, 32 x 32, two reads and one write
// register 0 reads zero, writes bypass to same-cycle reads
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module regfile import mips_pkg::*; (
	input  logic      clk,
	input  logic      rst_i,
	input  fwd_t      wb_i,
	input  reg_addr_t raddr1_i,
	input  reg_addr_t raddr2_i,
	output word_t     rdata1_o,
	output word_t     rdata2_o
);

	word_t regs [REG_NUM];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.wreg && (wb_i.wd != '0)) begin
			regs[wb_i.wd] <= wb_i.wdata;
		end
	end

	function automatic word_t read_port(input reg_addr_t addr);
		word_t res;
		if (addr == '0) begin
			res = '0;
		end else if (wb_i.wreg && (wb_i.wd == addr)) begin
			res = wb_i.wdata;	// write-through
		end else begin
			res = regs[addr];
		end
		return res;
	endfunction

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it
# exit status is non-zero unless the run prints the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_id_stage -f id_stage.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb_id_stage.sv
////////////////////////////////////////////////////////////
// testbench for the MIPS decode stage
// random instructions checked against a reference decode model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_id_stage import mips_pkg::*; ();

	logic    clk;
	logic    rst_i;
	word_t   pc_i;
	word_t   inst_i;
	logic    id_valid_i;
	fwd_t    ex_fwd_i;
	fwd_t    mem_fwd_i;
	logic    ex_is_load_i;
	fwd_t    wb_i;
	ex_req_t ex_req_o;
	branch_t branch_o;
	logic    stall_o;

	word_t       shadow [REG_NUM];	// reference register file
	logic        ds_ref;		// previous accepted instruction was a taken branch
	logic [31:0] seed;
	int          errors;
	int          checks;

	opcode_t rfn_tab [16] = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_SLLV, FN_SRLV, FN_SRAV,
		FN_SLL, FN_SRL, FN_SRA, FN_SLT, FN_SLTU, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU};
	aluop_e r_aluop [16] = '{ALU_OR, ALU_AND, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU};
	opcode_t iop_tab [8] = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
		OP_SLTI, OP_SLTIU, OP_ADDI, OP_ADDIU};
	aluop_e i_aluop [8] = '{ALU_OR, ALU_AND, ALU_XOR, ALU_OR,
		ALU_SLT, ALU_SLTU, ALU_ADDI, ALU_ADDIU};
	opcode_t bad_op [6] = '{6'b000001, 6'b011100, 6'b010000, 6'b100000, 6'b101000, 6'b110000};

	id_stage uut (.clk(clk), .rst_i(rst_i), .pc_i(pc_i), .inst_i(inst_i),
		.id_valid_i(id_valid_i), .ex_fwd_i(ex_fwd_i), .mem_fwd_i(mem_fwd_i),
		.ex_is_load_i(ex_is_load_i), .wb_i(wb_i), .ex_req_o(ex_req_o),
		.branch_o(branch_o), .stall_o(stall_o));

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// random sources
	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic int rnd(input int n);
		logic [31:0] r;
		r = lcg_next();
		return int'(r[31:16]) % n;	// upper bits, better period
	endfunction

	function automatic word_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[31:16], lo[31:16]};
	endfunction

	function automatic word_t rand_pc();
		word_t w;
		w = rand_word();
		return {w[31:2], 2'b00};
	endfunction

	function automatic fwd_t rand_wb(input int nreg);
		return '{wreg: 1'(rnd(2)), wd: reg_addr_t'(rnd(nreg)), wdata: rand_word()};
	endfunction

	// k picks one of the kept instructions, registers drawn from 0..nreg-1
	function automatic word_t gen_inst(input int k, input int nreg);
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] sa;
		word_t w;
		word_t res;
		rs = reg_addr_t'(rnd(nreg));
		rt = reg_addr_t'(rnd(nreg));
		rd = reg_addr_t'(rnd(32));
		sa = 5'(rnd(32));
		w  = rand_word();
		if (k < 16) begin
			if (k >= 7 && k <= 9) begin
				rs = '0;
			end else begin
				sa = '0;
			end
			res = {OP_SPECIAL, rs, rt, rd, sa, rfn_tab[k]};
		end else if (k < 24) begin
			res = {iop_tab[k - 16], rs, rt, w[15:0]};
		end else begin
			case (k)
				24: res = {OP_J, w[25:0]};
				25: res = {OP_JAL, w[25:0]};
				26: res = {OP_SPECIAL, rs, 15'd0, FN_JR};
				27: res = {OP_SPECIAL, rs, 5'd0, rd, 5'd0, FN_JALR};
				28: res = {OP_BEQ, rs, rt, w[15:0]};
				29: res = {OP_BNE, rs, rt, w[15:0]};
				30: res = {OP_BGTZ, rs, 5'd0, w[15:0]};
				31: res = {OP_BLEZ, rs, 5'd0, w[15:0]};
				32: res = {OP_LW, rs, rt, w[15:0]};
				default: res = {OP_SW, rs, rt, w[15:0]};
			endcase
		end
		return res;
	endfunction

	function automatic word_t bad_inst();
		word_t w;
		int r;
		w = rand_word();
		r = rnd(7);
		if (r < 6) begin
			w[31:26] = bad_op[r];
		end else begin
			w[31:26] = OP_SPECIAL;	// mult, not kept
			w[10:0]  = {5'd0, 6'b011000};
		end
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	function automatic dec_t decode_ref(input word_t inst);
		dec_t    d;
		opcode_t op;
		opcode_t fn;
		int      i;
		op = inst[31:26];
		fn = inst[5:0];
		d = '0;
		d.aluop     = ALU_NOP;
		d.alusel    = SEL_NOP;
		d.br_kind   = BR_NONE;
		d.reg1_addr = inst[25:21];
		d.reg2_addr = inst[20:16];
		case (op)
			OP_SPECIAL: begin
				for (i = 0; i < 16; i++) begin
					if (fn == rfn_tab[i]) begin
						d.aluop     = r_aluop[i];
						d.alusel    = (i < 4) ? SEL_LOGIC : ((i < 10) ? SEL_SHIFT : SEL_ARITHMETIC);
						d.wreg      = 1'b1;
						d.wd        = inst[15:11];
						d.reg1_read = (i < 7 || i > 9);	// sll/srl/sra use sa instead
						d.reg2_read = 1'b1;
						d.imm       = d.reg1_read ? '0 : {27'd0, inst[10:6]};
					end
				end
				if (fn == FN_JR || fn == FN_JALR) begin
					d.aluop     = (fn == FN_JR) ? ALU_JR : ALU_JALR;
					d.alusel    = SEL_JUMP_BRANCH;
					d.br_kind   = BR_JUMP_REG;
					d.reg1_read = 1'b1;
					d.wreg      = (fn == FN_JALR);
					d.link      = (fn == FN_JALR);
					d.wd        = inst[15:11];
				end
			end
			OP_J, OP_JAL: begin
				d.aluop   = (op == OP_JAL) ? ALU_JAL : ALU_J;
				d.alusel  = SEL_JUMP_BRANCH;
				d.br_kind = BR_JUMP;
				d.wreg    = (op == OP_JAL);
				d.link    = (op == OP_JAL);
				d.wd      = LINK_REG;
			end
			OP_BEQ, OP_BNE, OP_BGTZ, OP_BLEZ: begin
				d.alusel    = SEL_JUMP_BRANCH;
				d.reg1_read = 1'b1;
				d.reg2_read = (op == OP_BEQ || op == OP_BNE);
				d.aluop     = (op == OP_BEQ) ? ALU_BEQ : (op == OP_BNE) ? ALU_BNE :
					(op == OP_BGTZ) ? ALU_BGTZ : ALU_BLEZ;
				d.br_kind   = (op == OP_BEQ) ? BR_EQ : (op == OP_BNE) ? BR_NE :
					(op == OP_BGTZ) ? BR_GTZ : BR_LEZ;
			end
			OP_LW, OP_SW: begin
				d.aluop     = (op == OP_LW) ? ALU_LW : ALU_SW;
				d.alusel    = SEL_LOAD_STORE;
				d.reg1_read = 1'b1;
				d.reg2_read = (op == OP_SW);
				d.wreg      = (op == OP_LW);
				d.wd        = inst[20:16];
			end
			default: begin
				for (i = 0; i < 8; i++) begin
					if (op == iop_tab[i]) begin
						d.aluop     = i_aluop[i];
						d.alusel    = (i < 4) ? SEL_LOGIC : SEL_ARITHMETIC;
						d.wreg      = 1'b1;
						d.wd        = inst[20:16];
						d.reg1_read = 1'b1;
						if (i == 3) begin
							d.imm = {inst[15:0], 16'h0};	// lui
						end else if (i < 3) begin
							d.imm = {16'h0, inst[15:0]};
						end else begin
							d.imm = {{16{inst[15]}}, inst[15:0]};
						end
					end
				end
			end
		endcase
		return d;
	endfunction

	function automatic word_t operand_ref(input logic rd_en, input reg_addr_t a,
		input word_t imm, output logic hazard);
		word_t v;
		hazard = rd_en && ex_is_load_i && (ex_fwd_i.wd == a);
		if (!rd_en) begin
			v = imm;
		end else if (ex_fwd_i.wreg && ex_fwd_i.wd == a) begin
			v = ex_fwd_i.wdata;
		end else if (mem_fwd_i.wreg && mem_fwd_i.wd == a) begin
			v = mem_fwd_i.wdata;
		end else if (a == '0) begin
			v = '0;
		end else if (wb_i.wreg && wb_i.wd == a) begin
			v = wb_i.wdata;	// same-cycle write
		end else begin
			v = shadow[a];
		end
		return v;
	endfunction

	task automatic expect_true(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("FAIL t=%0t: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic drive(input word_t inst, input word_t pc, input logic valid);
		inst_i     = inst;
		pc_i       = pc;
		id_valid_i = valid;
	endtask

	// inputs are already applied after a falling edge
	task automatic check_cycle();
		dec_t  d;
		word_t op1;
		word_t op2;
		word_t pc4;
		word_t tgt;
		word_t link;
		logic  h1;
		logic  h2;
		logic  stl;
		logic  cond;
		logic  taken;
		logic  acc;
		#10;
		d    = decode_ref(inst_i);
		op1  = operand_ref(d.reg1_read, d.reg1_addr, d.imm, h1);
		op2  = operand_ref(d.reg2_read, d.reg2_addr, d.imm, h2);
		stl  = h1 | h2;
		pc4  = pc_i + 32'd4;
		cond = 1'b0;
		tgt  = pc4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};
		case (d.br_kind)
			BR_JUMP: begin
				cond = 1'b1;
				tgt  = {pc4[31:28], inst_i[25:0], 2'b00};
			end
			BR_JUMP_REG: begin
				cond = 1'b1;
				tgt  = op1;
			end
			BR_EQ:   cond = (op1 == op2);
			BR_NE:   cond = (op1 != op2);
			BR_GTZ:  cond = ($signed(op1) > 32'sd0);
			BR_LEZ:  cond = ($signed(op1) <= 32'sd0);
			default: ;
		endcase
		taken = cond & ~stl;
		link  = d.link ? pc_i + 32'd8 : '0;
		acc   = id_valid_i & ~stl;
		expect_true(stall_o === stl, $sformatf("stall_o %b expected %b", stall_o, stl));
		expect_true(branch_o.flag === taken, $sformatf("branch flag %b expected %b",
			branch_o.flag, taken));
		if (taken) begin
			expect_true(branch_o.target === tgt, $sformatf("target %h expected %h",
				branch_o.target, tgt));
		end
		@(posedge clk);
		if (wb_i.wreg && wb_i.wd != '0) begin
			shadow[wb_i.wd] = wb_i.wdata;
		end
		@(negedge clk);
		expect_true(ex_req_o.valid === acc, $sformatf("valid %b expected %b",
			ex_req_o.valid, acc));
		if (acc) begin
			expect_true(ex_req_o.aluop === d.aluop, $sformatf("aluop %h expected %h for %h",
				ex_req_o.aluop, d.aluop, inst_i));
			expect_true(ex_req_o.alusel === d.alusel, "alusel wrong");
			expect_true(ex_req_o.wreg === d.wreg, "wreg wrong");
			if (d.wreg) begin
				expect_true(ex_req_o.wd === d.wd, "destination register wrong");
			end
			expect_true(ex_req_o.reg1 === op1, $sformatf("reg1 %h expected %h",
				ex_req_o.reg1, op1));
			expect_true(ex_req_o.reg2 === op2, $sformatf("reg2 %h expected %h",
				ex_req_o.reg2, op2));
			expect_true(ex_req_o.link_addr === link, "link address wrong");
			expect_true(ex_req_o.in_delayslot === ds_ref, "delay-slot flag wrong");
			ds_ref = taken;
		end else begin
			expect_true(ex_req_o.aluop === ALU_NOP && ex_req_o.alusel === SEL_NOP &&
				ex_req_o.wreg === 1'b0 && ex_req_o.in_delayslot === 1'b0, "bubble not clean");
		end
	endtask

	task automatic wait_stall_low();
		int t;
		t = 0;
		#1;
		while (stall_o !== 1'b0 && t < 10) begin
			#2;
			t++;
		end
		if (stall_o !== 1'b0) begin
			$display("timeout: stall_o stayed high after the load-use hazard was removed");
			errors++;
		end
	endtask

	task automatic report_test(input int n, input string name, input int e0);
		$display("test %0d %s: %0d errors", n, name, errors - e0);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	initial begin
		int        k;
		int        e0;
		word_t     w;
		dec_t      d;
		reg_addr_t a;
		seed         = 32'h19db;
		errors       = 0;
		checks       = 0;
		ds_ref       = 1'b0;
		rst_i        = 1'b1;
		inst_i       = '0;
		pc_i         = '0;
		id_valid_i   = 1'b0;
		ex_fwd_i     = '0;
		mem_fwd_i    = '0;
		ex_is_load_i = 1'b0;
		wb_i         = '0;
		for (k = 0; k < REG_NUM; k++) begin
			shadow[k] = '0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;

		e0 = errors;
		expect_true(ex_req_o.valid === 1'b0 && ex_req_o.in_delayslot === 1'b0,
			"request not cleared by reset");
		for (k = 1; k < REG_NUM; k++) begin
			wb_i = '{wreg: 1'b1, wd: reg_addr_t'(k), wdata: rand_word()};
			drive('0, '0, 1'b0);
			check_cycle();
		end
		wb_i = '{wreg: 1'b1, wd: '0, wdata: rand_word()};	// dropped by register 0
		drive({OP_SPECIAL, 10'd0, 5'd1, 5'd0, FN_ADDU}, rand_pc(), 1'b1);
		check_cycle();
		wb_i = '0;
		repeat (40) begin
			drive(gen_inst(rnd(16), 32), rand_pc(), 1'b1);
			check_cycle();
		end
		report_test(1, "reset and R-type", e0);

		e0 = errors;
		repeat (60) begin
			k = rnd(11);
			k = (k < 3) ? k + 7 : k + 13;	// shifts by sa and immediates
			wb_i = rand_wb(32);
			drive(gen_inst(k, 32), rand_pc(), 1'b1);
			check_cycle();
		end
		report_test(2, "immediate and shift forms", e0);

		e0 = errors;
		repeat (80) begin
			ex_fwd_i  = rand_wb(8);
			mem_fwd_i = rand_wb(8);
			wb_i      = rand_wb(8);
			drive(gen_inst(rnd(24), 8), rand_pc(), 1'b1);
			check_cycle();
		end
		report_test(3, "forwarding priority", e0);

		e0 = errors;
		wb_i = '0;
		repeat (30) begin
			k = rnd(32);
			k = (k >= 24) ? k + 2 : k;	// register-reading branches, lw and sw too
			w = gen_inst(k, 8);
			d = decode_ref(w);
			a = (d.reg2_read && (!d.reg1_read || rnd(2) == 1)) ? d.reg2_addr : d.reg1_addr;
			ex_fwd_i     = '{wreg: 1'b1, wd: a, wdata: rand_word()};
			mem_fwd_i    = '0;
			ex_is_load_i = 1'b1;
			drive(w, rand_pc(), 1'b1);
			check_cycle();
			mem_fwd_i    = ex_fwd_i;	// load moves on to memory
			ex_fwd_i     = '0;
			ex_is_load_i = 1'b0;
			wait_stall_low();
			check_cycle();
		end
		report_test(4, "load-use stall", e0);

		e0 = errors;
		mem_fwd_i = '0;
		repeat (80) begin
			wb_i = rand_wb(8);
			k = (rnd(10) < 6) ? 24 + rnd(8) : rnd(24);
			if (rnd(8) == 0) begin
				drive('0, rand_pc(), 1'b0);
			end else begin
				drive(gen_inst(k, 8), rand_pc(), 1'b1);
			end
			check_cycle();
		end
		report_test(5, "branches, jumps and delay slots", e0);

		e0 = errors;
		wb_i = '0;
		repeat (30) begin
			drive(bad_inst(), rand_pc(), 1'b1);
			check_cycle();
		end
		report_test(6, "undecoded words", e0);

		$display("tests: 6, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#1000000;
		$display("simulation stopped at its time limit before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule
